/* bench/tb_pe_array.sv */
`default_nettype none

`include "pe_consts.svh"

module tb_pe_array;

	localparam int PERIOD = 40;
	localparam int ROUNDS = 4;
	localparam int PAIRS = 3;
	localparam int IDLE_MAX = 3;
	// Longest possible run summed over the sections.
	localparam int CYCLES = 10 + (8 + IDLE_MAX) + (16 + IDLE_MAX) + (8 + IDLE_MAX)
		+ ROUNDS * (4 + 4 + 2 + IDLE_MAX) + 1 + ROUNDS * (4 + PAIRS * (3 + IDLE_MAX));

	logic clk = 1'b0;
	logic reset;
	logic hp_en;
	logic [`A_W-1:0] a_in;
	logic a_en;
	logic [`N_PE-1:0][1:0] a_mux;
	logic [`A_W-1:0] a_out;
	logic [`B_W-1:0] b_in;
	logic [`N_PE-1:0] b_en;
	logic acc_en;
	logic [`RES_W-1:0] res_in;
	logic [`RES_W-1:0] res_out;
	logic config_en;
	logic config_in;
	logic config_out;

	logic [31:0] lfsr = 32'hbe1d7e5e;

	// Reference state. Both delay lines sit back to back in m_line.
	logic [7:0] m_line [2*`A_D];
	logic [7:0] m_mem [`N_PE][`B_D];
	logic [1:0] m_wptr [`N_PE];
	logic [1:0] m_cfg [`N_PE]; // Bit 0 a signed, bit 1 b signed.
	logic m_high [`N_PE];
	logic [1:0] m_addr [`N_PE];
	logic [31:0] m_acc [`N_PE];
	logic m_dly; // PE 1 steps a cycle after PE 0.

	pe_array u_dut (.*);

	always #(PERIOD/2) clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic int operand_value(input logic [7:0] x, input logic s);
		if (s) begin
			return int'($signed(x));
		end
		return int'(x);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("Regression failed");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	task automatic model_reset();
		for (int i = 0; i < 2*`A_D; i++) begin
			m_line[i] = '0;
		end
		for (int k = 0; k < `N_PE; k++) begin
			for (int i = 0; i < `B_D; i++) begin
				m_mem[k][i] = '0;
			end
			m_wptr[k] = '0;
			m_cfg[k] = '0;
			m_high[k] = 1'b0;
			m_addr[k] = '0;
			m_acc[k] = '0;
		end
		m_dly = 1'b0;
	endtask

	// Next register state from the inputs now on the pins.
	task automatic model_step();
		logic [31:0] n_acc [`N_PE];
		logic step [`N_PE];
		logic [31:0] chain_in;
		logic [1:0] tap;
		logic b_signed;
		int prod;
		step[0] = acc_en;
		step[1] = m_dly;
		for (int k = 0; k < `N_PE; k++) begin
			n_acc[k] = m_acc[k];
			if (step[k]) begin
				b_signed = m_cfg[k][1];
				if (hp_en && !m_high[k]) begin
					b_signed = 1'b0; // Low byte of a 16-bit weight is unsigned.
				end
				tap = a_mux[k];
				prod = operand_value(m_line[`A_D*k + tap], m_cfg[k][0])
					* operand_value(m_mem[k][m_addr[k]], b_signed);
				chain_in = res_in;
				if (k > 0) begin
					chain_in = m_acc[k-1];
				end
				if (m_high[k]) begin
					n_acc[k] = m_acc[k] + prod * 256; // High byte adds onto the own sum.
				end else begin
					n_acc[k] = chain_in + prod;
				end
				m_high[k] = hp_en & ~m_high[k];
				m_addr[k] = m_addr[k] + 2'd1;
			end
		end
		if (config_en) begin
			for (int k = `N_PE-1; k > 0; k--) begin
				m_cfg[k] = {m_cfg[k][0], m_cfg[k-1][1]};
			end
			m_cfg[0] = {m_cfg[0][0], config_in};
		end
		for (int k = 0; k < `N_PE; k++) begin
			if (b_en[k]) begin
				m_mem[k][m_wptr[k]] = b_in;
				m_wptr[k] = m_wptr[k] + 2'd1;
			end
		end
		if (a_en) begin
			for (int i = 2*`A_D-1; i > 0; i--) begin
				m_line[i] = m_line[i-1];
			end
			m_line[0] = a_in;
		end
		m_dly = acc_en;
		for (int k = 0; k < `N_PE; k++) begin
			m_acc[k] = n_acc[k];
		end
	endtask

	// One clock with the current inputs and a check at the falling edge.
	task automatic run_cycle();
		model_step();
		@(negedge clk);
		compare_value("res_out", res_out, m_acc[`N_PE-1]);
		compare_value("a_out", a_out, m_line[2*`A_D-1]);
		compare_value("config_out", config_out, m_cfg[`N_PE-1][1]);
	endtask

	task automatic idle_burst();
		logic [31:0] r;
		int cnt;
		get_bits(2, r);
		cnt = r[1:0];
		for (int i = 0; i < cnt; i++) begin
			get_bits(21, r);
			a_en = 1'b0;
			b_en = '0;
			acc_en = 1'b0;
			config_en = 1'b0;
			a_in = r[7:0]; // Data moves while the enables stay low.
			b_in = r[15:8];
			a_mux = r[19:16];
			config_in = r[20];
			run_cycle();
		end
	endtask

	task automatic shift_config(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			get_bits(1, r);
			config_en = 1'b1;
			config_in = r[0];
			run_cycle();
		end
		config_en = 1'b0;
	endtask

	task automatic stream_a(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			get_bits(9, r);
			a_in = r[7:0];
			a_en = r[8];
			run_cycle();
		end
		a_en = 1'b0;
	endtask

	task automatic load_weights();
		logic [31:0] r;
		for (int k = 0; k < `N_PE; k++) begin
			for (int i = 0; i < `B_D; i++) begin
				get_bits(8, r);
				b_in = r[7:0];
				b_en = '0;
				b_en[k] = 1'b1;
				run_cycle();
			end
		end
		b_en = '0;
	endtask

	task automatic mac_steps(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			get_bits(13, r);
			a_in = r[7:0];
			a_en = r[8];
			a_mux = r[12:9];
			acc_en = 1'b1;
			run_cycle();
		end
		acc_en = 1'b0;
		a_en = 1'b0;
		run_cycle();
		run_cycle(); // Last step has left PE 1.
	endtask

	task automatic hp_pair();
		logic [31:0] r;
		get_bits(4, r);
		a_mux = r[3:0]; // Same a word for both halves.
		a_en = 1'b0;
		acc_en = 1'b1;
		run_cycle();
		run_cycle();
		acc_en = 1'b0;
		run_cycle(); // PE 1 adds its high byte.
	endtask

	initial begin
		reset = 1'b1;
		hp_en = 1'b0;
		a_in = '0;
		a_en = 1'b0;
		a_mux = '0;
		b_in = '0;
		b_en = '0;
		acc_en = 1'b0;
		res_in = '0; // Chain input of PE 0.
		config_en = 1'b0;
		config_in = 1'b0;
		model_reset();
		repeat (10) @(negedge clk);
		compare_value("res_out", res_out, '0);
		compare_value("a_out", a_out, '0);
		compare_value("config_out", config_out, '0);
		reset = 1'b0;

		shift_config(8);
		idle_burst();
		stream_a(16);
		idle_burst();
		load_weights();
		idle_burst();
		for (int r = 0; r < ROUNDS; r++) begin
			shift_config(4); // Fresh signedness per round.
			mac_steps(4);
			idle_burst();
		end

		hp_en = 1'b1;
		run_cycle();
		for (int r = 0; r < ROUNDS; r++) begin
			shift_config(4);
			for (int p = 0; p < PAIRS; p++) begin
				hp_pair();
				idle_burst();
			end
		end

		$display("Regression passed");
		$finish;
	end

	initial begin
		#((CYCLES + 20) * PERIOD);
		$display("Timeout: the test sequence did not finish within %0d cycles.", CYCLES + 20);
		$display("Regression failed");
		$fatal(1, "Watchdog expired.");
	end

endmodule

`default_nettype wire

/* hw/accumulator.sv */
`default_nettype none

module accumulator (
	input wire clk,
	input wire reset,
	input wire acc_en,
	pe_ctrl_if.dp ctrl,
	input wire pe_pkg::res_t res_in,
	input wire pe_pkg::res_t shifter_res,
	output pe_pkg::res_t res_out
);
	import pe_pkg::*;

	res_t addend;

	// Chain from upstream, or add onto own sum in the second hp cycle.
	assign addend = ctrl.acc_mode ? res_out : res_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			res_out <= '0;
		end else if (acc_en) begin
			res_out <= shifter_res + addend;
		end
	end

endmodule

`default_nettype wire

/* hw/mult_flex.sv */
`default_nettype none

`include "pe_consts.svh"

module mult_flex (
	input wire pe_pkg::a_data_t a,
	input wire pe_pkg::b_data_t b,
	pe_ctrl_if.dp ctrl,
	output pe_pkg::prod_t res
);
	import pe_pkg::*;

	logic signed [`A_W:0] a_ext;
	logic signed [`B_W:0] b_ext;
	logic signed [`A_W+`B_W+1:0] full;

	// One extra bit makes unsigned operands positive in a signed multiply.
	assign a_ext = {ctrl.a_s & a[`A_W-1], a};
	assign b_ext = {ctrl.b_s & b[`B_W-1], b};

	assign full = a_ext * b_ext;
	assign res = full[`A_W+`B_W-1:0]; // Every mix fits in 16 bits.

endmodule

`default_nettype wire

/* hw/pe.sv */
`default_nettype none

module pe (
	input wire clk,
	input wire reset,
	input wire hp_en,
	input wire pe_pkg::a_data_t a,
	input wire a_en,
	input wire pe_pkg::a_tap_t a_mux,
	output pe_pkg::a_data_t a_out,
	input wire pe_pkg::b_data_t b,
	input wire b_en,
	output pe_pkg::b_data_t b_out,
	input wire acc_en,
	input wire pe_pkg::res_t res_in,
	output pe_pkg::res_t res_out,
	input wire config_en,
	input wire config_in,
	output logic config_out
);
	import pe_pkg::*;

	a_data_t mult_in_a;
	b_data_t mult_in_b;
	prod_t mult_res;
	res_t shifter_res;

	pe_ctrl_if ctrl ();

	stream_flex stream_flex_inst (
		.clk(clk),
		.reset(reset),
		.a(a),
		.a_en(a_en),
		.a_mux(a_mux),
		.mult_out(mult_in_a),
		.a_out(a_out)
	);

	stream_mem stream_mem_inst (
		.clk(clk),
		.reset(reset),
		.b(b),
		.b_en(b_en),
		.ctrl(ctrl.dp),
		.mult_out(mult_in_b),
		.b_out(b_out)
	);

	mult_flex mult_flex_inst (
		.a(mult_in_a),
		.b(mult_in_b),
		.ctrl(ctrl.dp),
		.res(mult_res)
	);

	shifter shifter_inst (
		.in(mult_res),
		.ctrl(ctrl.dp),
		.out(shifter_res)
	);

	accumulator accumulator_inst (
		.clk(clk),
		.reset(reset),
		.acc_en(acc_en),
		.ctrl(ctrl.dp),
		.res_in(res_in),
		.shifter_res(shifter_res),
		.res_out(res_out)
	);

	state_machine state_machine_inst (
		.clk(clk),
		.reset(reset),
		.hp_en(hp_en),
		.acc_en(acc_en),
		.config_en(config_en),
		.config_in(config_in),
		.config_out(config_out),
		.ctrl(ctrl.seq)
	);

endmodule

`default_nettype wire

/* hw/pe_array.sv */
`default_nettype none

`include "pe_consts.svh"

module pe_array (
	input wire clk,
	input wire reset,
	input wire hp_en,
	input wire pe_pkg::a_data_t a_in,
	input wire a_en,
	input wire pe_pkg::a_tap_t [`N_PE-1:0] a_mux,
	output pe_pkg::a_data_t a_out,
	input wire pe_pkg::b_data_t b_in,
	input wire [`N_PE-1:0] b_en,
	input wire acc_en,
	input wire pe_pkg::res_t res_in,
	output pe_pkg::res_t res_out,
	input wire config_en,
	input wire config_in,
	output logic config_out
);
	import pe_pkg::*;

	a_data_t a_chain [`N_PE+1];
	res_t res_chain [`N_PE+1];
	logic [`N_PE:0] cfg_chain;
	logic [`N_PE-2:0] acc_dly; // Step reaches PE k after k cycles.
	logic [`N_PE-1:0] acc_step;

	assign acc_step = {acc_dly, acc_en};

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_dly <= '0;
		end else begin
			acc_dly <= acc_step[`N_PE-2:0];
		end
	end

	assign a_chain[0] = a_in;
	assign res_chain[0] = res_in; // Chain input, tied to zero by the host.
	assign cfg_chain[0] = config_in;

	for (genvar k = 0; k < `N_PE; k++) begin : g_pe
		pe pe_inst (
			.clk(clk),
			.reset(reset),
			.hp_en(hp_en),
			.a(a_chain[k]),
			.a_en(a_en),
			.a_mux(a_mux[k]),
			.a_out(a_chain[k+1]),
			.b(b_in), // Shared bus, loaded per PE by b_en.
			.b_en(b_en[k]),
			.b_out(),
			.acc_en(acc_step[k]),
			.res_in(res_chain[k]),
			.res_out(res_chain[k+1]),
			.config_en(config_en),
			.config_in(cfg_chain[k]),
			.config_out(cfg_chain[k+1])
		);
	end

	assign a_out = a_chain[`N_PE];
	assign res_out = res_chain[`N_PE];
	assign config_out = cfg_chain[`N_PE];

endmodule

`default_nettype wire

/* hw/pe_consts.svh */
`ifndef PE_CONSTS_SVH
`define PE_CONSTS_SVH

// Datapath widths.
`define A_W 8
`define B_W 8
`define RES_W 32

// Storage depths and array shape.
`define A_D 4
`define B_D 4
`define CFG_BITS 2
`define N_PE 2

`endif

/* hw/pe_ctrl_if.sv */
`default_nettype none

interface pe_ctrl_if;
	import pe_pkg::*;

	logic a_s; // Operand a is signed.
	logic b_s; // Current b byte is signed.
	b_addr_t b_addr;
	shift_mode_t shift_mode;
	logic acc_mode; // 0 chains, 1 feeds back.

	modport seq (
		output a_s, b_s, b_addr, shift_mode, acc_mode
	);

	modport dp (
		input a_s, b_s, b_addr, shift_mode, acc_mode
	);

endinterface

`default_nettype wire

/* hw/pe_pkg.sv */
`default_nettype none

`include "pe_consts.svh"

package pe_pkg;

	typedef logic [`A_W-1:0] a_data_t;
	typedef logic [`B_W-1:0] b_data_t;
	typedef logic [`A_W+`B_W-1:0] prod_t; // Full 8x8 product.
	typedef logic [`RES_W-1:0] res_t;

	typedef logic [$clog2(`A_D)-1:0] a_tap_t;
	typedef logic [$clog2(`B_D)-1:0] b_addr_t;

	typedef logic shift_mode_t; // 0 keeps the product in place, 1 moves it up a byte.

	// Two-cycle split of a high-precision step.
	typedef enum logic {
		phase_low = 1'b0,
		phase_high = 1'b1
	} mac_phase_t;

endpackage

`default_nettype wire

/* hw/shifter.sv */
`default_nettype none

`include "pe_consts.svh"

module shifter (
	input wire pe_pkg::prod_t in,
	pe_ctrl_if.dp ctrl,
	output pe_pkg::res_t out
);
	import pe_pkg::*;

	logic ext_sign;
	res_t ext;

	// Product is signed whenever either operand was.
	assign ext_sign = (ctrl.a_s | ctrl.b_s) & in[`A_W+`B_W-1];
	assign ext = {{(`RES_W-`A_W-`B_W){ext_sign}}, in};

	// High byte of a 16-bit weight lands one byte up.
	assign out = (ctrl.shift_mode == 1'b1) ? (ext << `B_W) : ext;

endmodule

`default_nettype wire

/* hw/state_machine.sv */
`default_nettype none

`include "pe_consts.svh"

module state_machine (
	input wire clk,
	input wire reset,
	input wire hp_en,
	input wire acc_en,
	input wire config_en,
	input wire config_in,
	output logic config_out,
	pe_ctrl_if.seq ctrl
);
	import pe_pkg::*;

	logic [`CFG_BITS-1:0] cfg; // Bit 0 a signed, bit 1 b signed.
	mac_phase_t phase;
	b_addr_t addr;
	logic in_high;
	logic low_byte; // Unsigned low half of a 16-bit weight.

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg <= '0;
			phase <= phase_low;
			addr <= '0;
		end else begin
			if (config_en) begin
				cfg <= {cfg[`CFG_BITS-2:0], config_in}; // Shift toward the next PE.
			end
			if (acc_en) begin
				addr <= addr + 1'b1; // Even/odd pairs line up with the phase.
				if (hp_en && phase == phase_low) begin
					phase <= phase_high;
				end else begin
					phase <= phase_low;
				end
			end
		end
	end

	assign config_out = cfg[`CFG_BITS-1];

	assign in_high = (phase == phase_high);
	assign low_byte = hp_en & ~in_high;

	assign ctrl.a_s = cfg[0];
	assign ctrl.b_s = cfg[1] & ~low_byte;
	assign ctrl.b_addr = addr;
	assign ctrl.shift_mode = in_high;
	assign ctrl.acc_mode = in_high; // Second half adds onto the first.

endmodule

`default_nettype wire

/* hw/stream_flex.sv */
`default_nettype none

`include "pe_consts.svh"

module stream_flex (
	input wire clk,
	input wire reset,
	input wire pe_pkg::a_data_t a,
	input wire a_en,
	input wire pe_pkg::a_tap_t a_mux,
	output pe_pkg::a_data_t mult_out,
	output pe_pkg::a_data_t a_out
);
	import pe_pkg::*;

	a_data_t stage [`A_D];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `A_D; i++) begin
				stage[i] <= '0;
			end
		end else if (a_en) begin
			stage[0] <= a; // New word enters at the head.
			for (int i = 1; i < `A_D; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// Tap lets the PE keep using an older word while the stream moves on.
	assign mult_out = stage[a_mux];
	assign a_out = stage[`A_D-1]; // Tail feeds the next PE.

endmodule

`default_nettype wire

/* hw/stream_mem.sv */
`default_nettype none

`include "pe_consts.svh"

module stream_mem (
	input wire clk,
	input wire reset,
	input wire pe_pkg::b_data_t b,
	input wire b_en,
	pe_ctrl_if.dp ctrl,
	output pe_pkg::b_data_t mult_out,
	output pe_pkg::b_data_t b_out
);
	import pe_pkg::*;

	b_data_t mem [`B_D];
	b_addr_t wptr;

	always_ff @(posedge clk) begin
		if (reset) begin
			wptr <= '0;
			b_out <= '0;
			for (int i = 0; i < `B_D; i++) begin
				mem[i] <= '0;
			end
		end else if (b_en) begin
			mem[wptr] <= b;
			wptr <= wptr + 1'b1; // Wraps after B_D writes.
			b_out <= b; // Pass weight onward a cycle late.
		end
	end

	assign mult_out = mem[ctrl.b_addr]; // Sequencer picks the weight.

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/pe_pkg.sv
hw/pe_ctrl_if.sv
hw/stream_flex.sv
hw/stream_mem.sv
hw/mult_flex.sv
hw/shifter.sv
hw/accumulator.sv
hw/state_machine.sv
hw/pe.sv
hw/pe_array.sv
bench/tb_pe_array.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pe_array -f project.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_pe_array)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation ended with an error status"
	exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
